// File: all.f
+incdir+hdl
hdl/lh_tbl_pkg.sv
hdl/lh_pkt_pkg.sv
hdl/sync_fifo.sv
hdl/logic_hash_gen.sv
hdl/flow_table_apb.sv
hdl/logic_hash.sv
hdl/lh_subsys_top.sv
test/tb_lh_subsys.sv

// File: hdl/flow_table_apb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flow table with apb access
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "lh_defines.svh"

module flow_table_apb (
        input  logic clk,
        input  logic rst_n,
        input  lh_tbl_pkg::apb_req_t apb,
        output logic [`LH_APB_DATA_NBITS-1:0] prdata,
        output logic pready,
        output logic pslverr,
        output logic busy,
        input  logic lk_valid,
        input  lh_tbl_pkg::lh_fid_t lk_fid,
        output lh_tbl_pkg::tbl_rd_t lk_data
);

        import lh_tbl_pkg::*;

        typedef enum logic {CLEAR, RUN} tbl_state_e;

        tbl_state_e state;
        lh_fid_t clr_addr;
        lh_hash_t hash_stage;
        lh_sn_t sn_stage;
        logic access;
        logic mapped;
        logic commit_wr;
        lh_fid_t commit_fid;
        logic ram_wr;
        lh_fid_t ram_addr;
        lh_hash_t hash_ram [1 << `LH_FID_NBITS];
        lh_sn_t sn_ram [1 << `LH_FID_NBITS];

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // apb slave
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        assign busy = (state == CLEAR);
        // no wait states once the clear is over
        assign pready = (state == RUN);
        assign access = apb.psel & apb.penable & pready;

        always_comb begin
                mapped = 1'b1;
                prdata = '0;
                case (lh_reg_e'(apb.paddr))
                        HASH_STAGE: prdata = hash_stage;
                        SN_STAGE: prdata[`LH_SN_NBITS-1:0] = sn_stage;
                        COMMIT: prdata = '0;
                        default: mapped = 1'b0;
                endcase
        end

        assign pslverr = access & ~mapped;

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        state <= CLEAR;
                        clr_addr <= '0;
                        hash_stage <= '0;
                        sn_stage <= '0;
                        commit_wr <= 1'b0;
                end else begin
                        if (state == CLEAR) begin
                                clr_addr <= clr_addr + 1'b1;
                                if (&clr_addr)
                                        state <= RUN;
                        end
                        commit_wr <= 1'b0;
                        if (access && apb.pwrite && mapped) begin
                                case (lh_reg_e'(apb.paddr))
                                        HASH_STAGE: hash_stage <= apb.pwdata;
                                        SN_STAGE: sn_stage <= apb.pwdata[`LH_SN_NBITS-1:0];
                                        COMMIT: commit_wr <= 1'b1;
                                        default: commit_wr <= 1'b0;
                                endcase
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (access && apb.pwrite && mapped) begin
                        commit_fid <= apb.pwdata[`LH_FID_NBITS-1:0];
                end
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // table rams
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        // the clear owns the write port until every flow is zeroed
        assign ram_wr = busy | commit_wr;
        assign ram_addr = busy ? clr_addr : commit_fid;

        always_ff @(posedge clk) begin
                if (ram_wr) begin
                        hash_ram[ram_addr] <= busy ? '0 : hash_stage;
                        sn_ram[ram_addr] <= busy ? '0 : sn_stage;
                end
                if (lk_valid) begin
                        lk_data.hash <= hash_ram[lk_fid];
                        lk_data.sn <= sn_ram[lk_fid];
                end
        end

endmodule

// File: hdl/lh_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// logic hash widths and depths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef LH_DEFINES_SVH
`define LH_DEFINES_SVH

// header beat and the folded hash
`define LH_DATA_NBITS 128
`define LH_HASH_NBITS 32

// serial number field sits at the top of the sop beat
`define LH_SN_NBITS 16
`define LH_SN_POS 127

// 64 flows
`define LH_FID_NBITS 6

`define LH_BUF_DEPTH_NBITS 5

`define LH_APB_ADDR_NBITS 8
`define LH_APB_DATA_NBITS 32

`endif

// File: hdl/lh_pkt_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet side types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "lh_defines.svh"

package lh_pkt_pkg;

        typedef logic [`LH_DATA_NBITS-1:0] lh_data_t;

        // per packet meta, repeated on every beat
        typedef struct packed {
                lh_tbl_pkg::lh_fid_t fid;
                logic [7:0] tid;
                logic [13:0] len;
                logic [3:0] port;
                logic type1;
                logic discard;
        } lh_meta_t;

        typedef struct packed {
                lh_data_t data;
                lh_meta_t meta;
                logic sop;
                logic eop;
        } lh_beat_t;

        typedef struct packed {
                lh_tbl_pkg::lh_fid_t fid;
                lh_tbl_pkg::lh_hash_t hash;
        } lh_hash_rpt_t;

endpackage

// File: hdl/lh_subsys_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// logic hash subsystem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "lh_defines.svh"

module lh_subsys_top (
        input  logic clk,
        input  logic rst_n,
        input  lh_tbl_pkg::apb_req_t apb,
        output logic [`LH_APB_DATA_NBITS-1:0] prdata,
        output logic pready,
        output logic pslverr,
        input  lh_pkt_pkg::lh_beat_t in_beat,
        input  logic in_valid,
        output logic in_ready,
        output lh_pkt_pkg::lh_beat_t out_beat,
        output logic out_valid,
        input  logic out_ready,
        output lh_pkt_pkg::lh_hash_rpt_t rpt,
        output logic rpt_valid,
        input  logic rpt_ready
);

        import lh_tbl_pkg::*;

        logic busy;
        logic lk_valid;
        lh_fid_t lk_fid;
        tbl_rd_t lk_data;

        flow_table_apb u_flow_table_apb (
                .clk(clk),
                .rst_n(rst_n),
                .apb(apb),
                .prdata(prdata),
                .pready(pready),
                .pslverr(pslverr),
                .busy(busy),
                .lk_valid(lk_valid),
                .lk_fid(lk_fid),
                .lk_data(lk_data)
        );

        logic_hash u_logic_hash (
                .clk(clk),
                .rst_n(rst_n),
                .in_beat(in_beat),
                .in_valid(in_valid),
                .in_ready(in_ready),
                .busy(busy),
                .lk_valid(lk_valid),
                .lk_fid(lk_fid),
                .lk_data(lk_data),
                .out_beat(out_beat),
                .out_valid(out_valid),
                .out_ready(out_ready),
                .rpt(rpt),
                .rpt_valid(rpt_valid),
                .rpt_ready(rpt_ready)
        );

endmodule

// File: hdl/lh_tbl_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flow table types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "lh_defines.svh"

package lh_tbl_pkg;

        typedef logic [`LH_FID_NBITS-1:0] lh_fid_t;
        typedef logic [`LH_HASH_NBITS-1:0] lh_hash_t;
        typedef logic [`LH_SN_NBITS-1:0] lh_sn_t;

        typedef struct packed {
                logic psel;
                logic penable;
                logic pwrite;
                logic [`LH_APB_ADDR_NBITS-1:0] paddr;
                logic [`LH_APB_DATA_NBITS-1:0] pwdata;
        } apb_req_t;

        // a write to COMMIT carries the fid in its low bits
        typedef enum logic [`LH_APB_ADDR_NBITS-1:0] {
                HASH_STAGE = 'h00,
                SN_STAGE = 'h04,
                COMMIT = 'h08
        } lh_reg_e;

        typedef struct packed {
                lh_hash_t hash;
                lh_sn_t sn;
        } tbl_rd_t;

endpackage

// File: hdl/logic_hash.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// header hash and serial number checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "lh_defines.svh"

module logic_hash (
        input  logic clk,
        input  logic rst_n,
        input  lh_pkt_pkg::lh_beat_t in_beat,
        input  logic in_valid,
        output logic in_ready,
        input  logic busy,
        output logic lk_valid,
        output lh_tbl_pkg::lh_fid_t lk_fid,
        input  lh_tbl_pkg::tbl_rd_t lk_data,
        output lh_pkt_pkg::lh_beat_t out_beat,
        output logic out_valid,
        input  logic out_ready,
        output lh_pkt_pkg::lh_hash_rpt_t rpt,
        output logic rpt_valid,
        input  logic rpt_ready
);

        import lh_pkt_pkg::*;
        import lh_tbl_pkg::*;

        typedef struct packed {
                lh_hash_t exp_hash;
                logic sn_ok;
                lh_hash_t gen_hash;
        } verdict_t;

        typedef enum logic [1:0] {IDLE, SEND, WAIT_RPT} out_state_e;

        out_state_e state;
        logic fire;
        logic bf_empty;
        logic bf_afull;
        logic bf_rd;
        lh_beat_t bf_head;
        lh_sn_t pkt_sn;
        logic lk_ack;
        logic tbl_sn_ok;
        lh_hash_t pend_hash;
        logic pend_sn_ok;
        logic gen_valid;
        lh_hash_t gen_hash;
        verdict_t vf_din;
        verdict_t vf_head;
        logic vf_empty;
        logic vf_rd;
        logic hash_bad;
        logic sn_bad;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // input side
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        assign in_ready = ~busy & ~bf_afull;
        assign fire = in_valid & in_ready;
        assign lk_valid = fire & in_beat.sop;
        assign lk_fid = in_beat.meta.fid;

        assign tbl_sn_ok = (lk_data.sn == pkt_sn);

        always_ff @(posedge clk) begin
                if (lk_valid) begin
                        pkt_sn <= in_beat.data[`LH_SN_POS -: `LH_SN_NBITS];
                end
                if (lk_ack) begin
                        pend_hash <= lk_data.hash;
                        pend_sn_ok <= tbl_sn_ok;
                end
        end

        // a one beat packet brings the table result and its hash in the same cycle,
        // otherwise the table result has been waiting in the pending registers
        assign vf_din.exp_hash = lk_ack ? lk_data.hash : pend_hash;
        assign vf_din.sn_ok = lk_ack ? tbl_sn_ok : pend_sn_ok;
        assign vf_din.gen_hash = gen_hash;

        logic_hash_gen u_logic_hash_gen (
                .clk(clk),
                .rst_n(rst_n),
                .beat(in_beat),
                .fire(fire),
                .hash_valid(gen_valid),
                .hash(gen_hash)
        );

        sync_fifo #(
                .width($bits(lh_beat_t)),
                .depth_nbits(`LH_BUF_DEPTH_NBITS)
        ) u_beat_fifo (
                .clk(clk),
                .rst_n(rst_n),
                .wr(fire),
                .din(in_beat),
                .rd(bf_rd),
                .dout(bf_head),
                .empty(bf_empty),
                .almost_full(bf_afull)
        );

        // never holds more entries than the beat fifo, so it cannot overflow
        sync_fifo #(
                .width($bits(verdict_t)),
                .depth_nbits(`LH_BUF_DEPTH_NBITS)
        ) u_verdict_fifo (
                .clk(clk),
                .rst_n(rst_n),
                .wr(gen_valid),
                .din(vf_din),
                .rd(vf_rd),
                .dout(vf_head),
                .empty(vf_empty),
                .almost_full()
        );

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // output side
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        assign out_valid = (state == SEND) & ~bf_empty;
        assign bf_rd = out_valid & out_ready;
        assign vf_rd = (state == IDLE) & ~vf_empty;

        always_comb begin
                out_beat = bf_head;
                out_beat.meta.discard = bf_head.meta.discard | hash_bad;
                out_beat.meta.type1 = bf_head.meta.type1 & ~sn_bad;
        end

        // the head of the beat fifo is the sop of the packet this verdict belongs to
        always_ff @(posedge clk) begin
                if (vf_rd) begin
                        hash_bad <= (vf_head.exp_hash != vf_head.gen_hash);
                        sn_bad <= ~vf_head.sn_ok;
                        rpt.fid <= bf_head.meta.fid;
                        rpt.hash <= vf_head.gen_hash;
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        state <= IDLE;
                        rpt_valid <= 1'b0;
                        lk_ack <= 1'b0;
                end else begin
                        lk_ack <= lk_valid;
                        if (rpt_valid && rpt_ready)
                                rpt_valid <= 1'b0;
                        case (state)
                                IDLE: begin
                                        if (!vf_empty) begin
                                                rpt_valid <= 1'b1;
                                                state <= SEND;
                                        end
                                end
                                SEND: begin
                                        if (bf_rd && bf_head.eop)
                                                state <= (rpt_valid && !rpt_ready) ? WAIT_RPT : IDLE;
                                end
                                WAIT_RPT: begin
                                        if (rpt_ready)
                                                state <= IDLE;
                                end
                                default: state <= IDLE;
                        endcase
                end
        end

endmodule

// File: hdl/logic_hash_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// header hash generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "lh_defines.svh"

module logic_hash_gen (
        input  logic clk,
        input  logic rst_n,
        input  lh_pkt_pkg::lh_beat_t beat,
        input  logic fire,
        output logic hash_valid,
        output lh_tbl_pkg::lh_hash_t hash
);

        import lh_tbl_pkg::*;

        localparam int n_words = `LH_DATA_NBITS / `LH_HASH_NBITS;

        lh_hash_t fold;
        lh_hash_t acc;
        lh_hash_t acc_rot;
        lh_hash_t acc_next;

        // xor of all words in the beat
        always_comb begin
                fold = '0;
                for (int i = 0; i < n_words; i++) begin
                        fold = fold ^ beat.data[i*`LH_HASH_NBITS +: `LH_HASH_NBITS];
                end
        end

        assign acc_rot = {acc[`LH_HASH_NBITS-2:0], acc[`LH_HASH_NBITS-1]};

        // sop starts the packet from zero
        assign acc_next = (beat.sop ? '0 : acc_rot) ^ fold;

        always_ff @(posedge clk) begin
                if (fire) begin
                        acc <= acc_next;
                end
                if (fire && beat.eop) begin
                        hash <= acc_next;
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        hash_valid <= 1'b0;
                end else begin
                        hash_valid <= fire & beat.eop;
                end
        end

endmodule

// File: hdl/sync_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// synchronous show-ahead FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sync_fifo #(
        parameter int width = 8,
        parameter int depth_nbits = 4
) (
        input  logic clk,
        input  logic rst_n,
        input  logic wr,
        input  logic [width-1:0] din,
        input  logic rd,
        output logic [width-1:0] dout,
        output logic empty,
        output logic almost_full
);

        localparam int depth = 1 << depth_nbits;

        logic [width-1:0] mem [depth];
        logic [depth_nbits:0] wr_ptr;
        logic [depth_nbits:0] rd_ptr;
        logic [depth_nbits:0] count;

        // pointers carry one extra bit so full and empty differ
        assign count = wr_ptr - rd_ptr;
        assign empty = (count == '0);
        assign almost_full = (int'(count) >= depth - 2);
        assign dout = mem[rd_ptr[depth_nbits-1:0]];

        always_ff @(posedge clk) begin
                if (wr) begin
                        mem[wr_ptr[depth_nbits-1:0]] <= din;
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        if (wr)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (rd)
                                rd_ptr <= rd_ptr + 1'b1;
                end
        end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the logic hash testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_lh_subsys -f all.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Verification failed" sim.log; then
        echo "simulation reported a failure"
        exit 1
fi

echo "simulation finished without failure"

// File: test/lh_golden.txt
# W fid hash sn : flow table entry written over APB
# B data fid tid len port type1 discard sop eop : one input beat
# E discard type1 hash : expected meta bits and generated hash of the packet above
W 01 111100a5 1111
W 02 44440102 2222
W 05 81540007 0055
W 3f 00000007 0007
B 111100000000000000000000000000a5 01 10 0010 1 1 0 1 1
E 0 1 111100a5
B 22220000000000000000000000000001 02 11 0020 2 1 0 1 0
B 00000000000000000000000000000100 02 11 0020 2 1 0 0 1
E 0 1 44440102
B 22230000000100000000000000000001 02 12 0020 2 1 0 1 0
B 00000000000000000000000000000100 02 12 0020 2 1 0 0 1
E 0 0 44440102
B 00550000000000000000000000000000 05 13 0030 3 0 0 1 0
B 00000000000000000000000000000003 05 13 0030 3 0 0 0 0
B 00000000000000008000000000000000 05 13 0030 3 0 0 0 1
E 1 0 81540006
B 000000000000beef0000000000000000 00 14 0010 4 1 0 1 1
E 1 1 0000beef
B 12345678123456780000000000000000 00 15 0010 5 1 0 1 1
E 0 0 00000000
B 00550000000000000000000000000000 05 16 0030 6 1 1 1 0
B 00000000000000000000000000000003 05 16 0030 6 1 1 0 0
B 00000000000000008000000100000000 05 16 0030 6 1 1 0 1
E 1 1 81540007
B 11110000000000000000000000000010 01 17 0040 7 0 0 1 0
B 00000000000000000000000000000000 01 17 0040 7 0 0 0 0
B 00000000000000000000000000000001 01 17 0040 7 0 0 0 0
B 00000000000000009999002700000000 01 17 0040 7 0 0 0 1
E 0 0 111100a5
B abcd0000000000000000000000000000 02 18 0010 8 1 0 1 1
E 1 0 abcd0000
B 00070000000700000000000000000000 3f 19 0020 9 1 0 1 0
B 00000000000000000000000000000007 3f 19 0020 9 1 0 0 1
E 0 1 00000007

// File: test/tb_lh_subsys.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// logic hash subsystem testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "lh_defines.svh"

module tb_lh_subsys;

        import lh_pkt_pkg::*;
        import lh_tbl_pkg::*;

        logic clk;
        logic rst_n;
        apb_req_t apb;
        logic [`LH_APB_DATA_NBITS-1:0] prdata;
        logic pready;
        logic pslverr;
        lh_beat_t in_beat;
        logic in_valid;
        logic in_ready;
        lh_beat_t out_beat;
        logic out_valid;
        logic out_ready;
        lh_hash_rpt_t rpt;
        logic rpt_valid;
        logic rpt_ready;

        lh_fid_t tbl_fid [$];
        lh_hash_t tbl_hash [$];
        lh_sn_t tbl_sn [$];
        lh_beat_t stim [$];
        lh_beat_t exp_beats [$];
        lh_hash_rpt_t exp_rpt [$];
        int errors;
        int n_out;
        int n_rpt;
        int cycles = 0;
        int cycle_limit = 500;

        lh_subsys_top i_lh_subsys_top (
                .clk(clk),
                .rst_n(rst_n),
                .apb(apb),
                .prdata(prdata),
                .pready(pready),
                .pslverr(pslverr),
                .in_beat(in_beat),
                .in_valid(in_valid),
                .in_ready(in_ready),
                .out_beat(out_beat),
                .out_valid(out_valid),
                .out_ready(out_ready),
                .rpt(rpt),
                .rpt_valid(rpt_valid),
                .rpt_ready(rpt_ready)
        );

        always #2 clk = ~clk;

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= cycle_limit) begin
                        $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
                        $display("Verification failed");
                        $finish;
                end
        end

        task automatic compare(input string name, input logic [191:0] got,
                               input logic [191:0] exp);
                if (got !== exp) begin
                        errors++;
                        $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
                end
        endtask

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // golden file
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        task automatic load_golden(output logic ok);
                int fd;
                int n;
                int pkt_start;
                string line;
                logic [`LH_DATA_NBITS-1:0] data;
                logic [31:0] f0, f1, f2, f3, f4, f5, f6, f7;
                lh_beat_t b;
                lh_hash_rpt_t r;
                pkt_start = 0;
                fd = $fopen("test/lh_golden.txt", "r");
                ok = (fd != 0);
                if (!ok) begin
                        errors++;
                        $display("cannot open the golden file test/lh_golden.txt");
                end
                while (ok && !$feof(fd)) begin
                        line = "";
                        n = $fgets(line, fd);
                        case (line.getc(0))
                                "W": begin
                                        n = $sscanf(line, "W %h %h %h", f0, f1, f2);
                                        compare("golden W fields", 192'(n), 192'(3));
                                        tbl_fid.push_back(f0[`LH_FID_NBITS-1:0]);
                                        tbl_hash.push_back(f1);
                                        tbl_sn.push_back(f2[`LH_SN_NBITS-1:0]);
                                end
                                "B": begin
                                        n = $sscanf(line, "B %h %h %h %h %h %h %h %h %h",
                                                    data, f0, f1, f2, f3, f4, f5, f6, f7);
                                        compare("golden B fields", 192'(n), 192'(9));
                                        b.data = data;
                                        b.meta.fid = f0[`LH_FID_NBITS-1:0];
                                        b.meta.tid = f1[7:0];
                                        b.meta.len = f2[13:0];
                                        b.meta.port = f3[3:0];
                                        b.meta.type1 = f4[0];
                                        b.meta.discard = f5[0];
                                        b.sop = f6[0];
                                        b.eop = f7[0];
                                        if (b.sop)
                                                pkt_start = exp_beats.size();
                                        stim.push_back(b);
                                        exp_beats.push_back(b);
                                end
                                "E": begin
                                        n = $sscanf(line, "E %h %h %h", f0, f1, f2);
                                        compare("golden E fields", 192'(n), 192'(3));
                                        // the verdict rewrites meta on every beat of the packet
                                        for (int i = pkt_start; i < exp_beats.size(); i++) begin
                                                b = exp_beats[i];
                                                b.meta.discard = f0[0];
                                                b.meta.type1 = f1[0];
                                                exp_beats[i] = b;
                                        end
                                        r.fid = exp_beats[pkt_start].meta.fid;
                                        r.hash = f2;
                                        exp_rpt.push_back(r);
                                end
                                default: ;
                        endcase
                end
                if (ok)
                        $fclose(fd);
        endtask

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // bus and stream drivers
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        task automatic apb_xfer(input logic wr, input logic [`LH_APB_ADDR_NBITS-1:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
                apb.psel = 1'b1;
                apb.penable = 1'b0;
                apb.pwrite = wr;
                apb.paddr = addr;
                apb.pwdata = wdata;
                @(negedge clk);
                apb.penable = 1'b1;
                while (!pready)
                        @(negedge clk);
                #1;
                rdata = prdata;
                err = pslverr;
                @(negedge clk);
                apb.psel = 1'b0;
                apb.penable = 1'b0;
        endtask

        task automatic drive_beats();
                for (int i = 0; i < stim.size(); i++) begin
                        in_beat = stim[i];
                        in_valid = 1'b1;
                        while (!in_ready)
                                @(negedge clk);
                        @(negedge clk);
                end
                in_valid = 1'b0;
                in_beat = '0;
        endtask

        task automatic collect_outputs();
                logic take_beat;
                logic take_rpt;
                while (n_out < exp_beats.size() || n_rpt < exp_rpt.size()) begin
                        @(negedge clk);
                        take_beat = ($urandom % 4) != 0;
                        take_rpt = ($urandom % 3) != 0;
                        out_ready = take_beat;
                        rpt_ready = take_rpt;
                        if (out_valid && take_beat) begin
                                if (n_out < exp_beats.size()) begin
                                        compare("out_beat.data", 192'(out_beat.data),
                                                192'(exp_beats[n_out].data));
                                        compare("out_beat.meta", 192'(out_beat.meta),
                                                192'(exp_beats[n_out].meta));
                                        compare("out_beat.sop", 192'(out_beat.sop),
                                                192'(exp_beats[n_out].sop));
                                        compare("out_beat.eop", 192'(out_beat.eop),
                                                192'(exp_beats[n_out].eop));
                                end else begin
                                        errors++;
                                        $display("an output beat came out beyond the expected count");
                                end
                                n_out++;
                        end
                        if (rpt_valid && take_rpt) begin
                                if (n_rpt < exp_rpt.size()) begin
                                        compare("rpt.fid", 192'(rpt.fid), 192'(exp_rpt[n_rpt].fid));
                                        compare("rpt.hash", 192'(rpt.hash), 192'(exp_rpt[n_rpt].hash));
                                end else begin
                                        errors++;
                                        $display("a hash report came out beyond the expected count");
                                end
                                n_rpt++;
                        end
                end
        endtask

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // test sequence
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        initial begin
                logic ok;
                logic [31:0] rdata;
                logic err;
                int low_cycles;
                lh_hash_t last_hash;
                clk = 1'b0;
                rst_n = 1'b0;
                apb = '0;
                in_beat = '0;
                in_valid = 1'b0;
                out_ready = 1'b0;
                rpt_ready = 1'b0;
                errors = 0;
                n_out = 0;
                n_rpt = 0;
                last_hash = '0;
                void'($urandom(79393));
                load_golden(ok);
                cycle_limit = 20 * stim.size() + 500;
                if (ok) begin
                        repeat (10)
                                @(negedge clk);
                        rst_n = 1'b1;
                        compare("out_valid", 192'(out_valid), 192'(0));
                        compare("rpt_valid", 192'(rpt_valid), 192'(0));
                        // the table clear takes one cycle per flow
                        low_cycles = 0;
                        while (!pready) begin
                                compare("in_ready", 192'(in_ready), 192'(0));
                                low_cycles++;
                                @(negedge clk);
                        end
                        compare("clear cycles", 192'(low_cycles), 192'(1 << `LH_FID_NBITS));

                        for (int i = 0; i < tbl_fid.size(); i++) begin
                                apb_xfer(1'b1, HASH_STAGE, tbl_hash[i], rdata, err);
                                apb_xfer(1'b0, HASH_STAGE, 32'h0, rdata, err);
                                compare("prdata hash stage", 192'(rdata), 192'(tbl_hash[i]));
                                apb_xfer(1'b1, SN_STAGE, 32'(tbl_sn[i]), rdata, err);
                                apb_xfer(1'b0, SN_STAGE, 32'h0, rdata, err);
                                compare("prdata sn stage", 192'(rdata), 192'(tbl_sn[i]));
                                apb_xfer(1'b1, COMMIT, 32'(tbl_fid[i]), rdata, err);
                                compare("pslverr", 192'(err), 192'(0));
                                last_hash = tbl_hash[i];
                        end
                        // an unmapped write must not touch the staging registers
                        apb_xfer(1'b1, 8'h0c, 32'hdeadbeef, rdata, err);
                        compare("pslverr", 192'(err), 192'(1));
                        apb_xfer(1'b0, HASH_STAGE, 32'h0, rdata, err);
                        compare("prdata hash stage", 192'(rdata), 192'(last_hash));

                        fork
                                drive_beats();
                                collect_outputs();
                        join
                        out_ready = 1'b1;
                        rpt_ready = 1'b1;
                        repeat (20) begin
                                @(negedge clk);
                                compare("out_valid", 192'(out_valid), 192'(0));
                                compare("rpt_valid", 192'(rpt_valid), 192'(0));
                        end
                end
                $display("errors %0d, beats %0d of %0d, reports %0d of %0d", errors, n_out,
                         exp_beats.size(), n_rpt, exp_rpt.size());
                if (errors == 0) begin
                        $display("Verification passed");
                end else begin
                        $display("Verification failed");
                end
                $finish;
        end

endmodule
